// ==== logic/memPkg.sv ====
package memPkg;

    // the PC that the core fetches from after reset.
    localparam logic [31:0] resetVector = 32'hBFC00000;

    localparam int memWords = 1024;     // depth of the unified SRAM in words.
    localparam int memIndexBits = 10;   // the word index comes from address bits 11:2.

    // width of a single load or store.
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

    // one request toward the SRAM port.
    typedef struct packed {
        logic        valid;        // request is present this cycle.
        logic        write;        // store when set, otherwise a read.
        logic [31:0] addr;         // byte address, word aligned by the requester.
        logic [31:0] wdata;        // store data already placed on its lanes.
        logic [3:0]  byteEnable;   // one bit per byte lane of wdata.
    } memRequest;

    // the SRAM answer, one cycle after a granted request.
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;        // undefined after a write.
    } memResponse;

    // a load or store as the pipeline hands it to the data unit.
    typedef struct packed {
        logic        write;
        accessSize   size;
        logic        signedLoad;   // sign-extend a byte or halfword load.
        logic [31:0] addr;
        logic [31:0] wdata;        // store value in the low bits.
    } dataCommand;

endpackage

// ==== logic/instructionFetch.sv ====
`timescale 1ns/100ps

module instructionFetch (
    input  logic               clk,
    input  logic               reset,
    input  logic               absJump,
    input  logic               pcStall,
    input  logic               hang,
    input  logic [31:0]        absJumpAddress,
    input  memPkg::memResponse fetchResp,
    output memPkg::memRequest  fetchReq,
    output logic [31:0]        outputPC,
    output logic [31:0]        instruction,
    output logic               exception,
    output logic               bubble
);

    logic [31:0] pc;
    logic [31:0] nextPC;
    logic        hangState;
    logic        isHanging;
    logic        pendingRead;
    logic        pendingJump;
    logic [31:0] pendingJumpAddr;
    logic        deferJump;
    logic        takeJump;

    assign isHanging = hang || hangState;

    // the word for the current PC has not arrived yet.
    assign pendingRead = !pcStall && !fetchResp.valid;

    assign bubble = hangState || pendingRead;
    assign outputPC = hangState ? '0 : pc;
    assign instruction = isHanging ? '0 : fetchResp.rdata;

    // a misaligned PC is only reported while fetch is live.
    assign exception = !hangState && (pc[1:0] != 2'b00);

    always_comb begin
        nextPC = pc;
        deferJump = 1'b0;
        takeJump = 1'b0;
        if (reset) begin
            nextPC = memPkg::resetVector;
        end else if (pcStall || pendingRead) begin
            deferJump = absJump;                 // hold the PC and remember the jump.
        end else if (absJump) begin
            nextPC = absJumpAddress;
            takeJump = 1'b1;
        end else if (pendingJump) begin
            nextPC = pendingJumpAddr;
            takeJump = 1'b1;
        end else if (!isHanging) begin
            nextPC = pc + 32'd4;
        end
    end

    // fetch always reads. The address is the PC of the next cycle.
    always_comb begin
        fetchReq.valid = 1'b1;
        fetchReq.write = 1'b0;
        fetchReq.addr = nextPC;
        fetchReq.wdata = '0;
        fetchReq.byteEnable = 4'b1111;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hangState <= 1'b0;
            pendingJump <= 1'b0;
        end else begin
            if (takeJump) begin
                hangState <= 1'b0;                  // any jump leaves the hang state.
            end else if (!pcStall && absJump) begin
                hangState <= 1'b0;
            end else if (!pcStall && hang) begin
                hangState <= 1'b1;
            end
            if (deferJump) begin
                pendingJump <= 1'b1;
            end else if (takeJump) begin
                pendingJump <= 1'b0;
            end
        end
        pc <= nextPC;                               // reset loads the vector through nextPC.
        if (deferJump) begin
            pendingJumpAddr <= absJumpAddress;
        end
    end

    // entering the hang state blanks the visible PC on the next cycle.
    assert property (@(posedge clk) disable iff (reset)
        (hang && !pcStall && !absJump && !takeJump) |=> (outputPC == '0));

    // no alignment fault is reported once fetch has been parked.
    assert property (@(posedge clk) disable iff (reset)
        (hang && !pcStall && !absJump && !takeJump) |=> !exception);

endmodule

// ==== logic/dataAccess.sv ====
`timescale 1ns/100ps

module dataAccess (
    input  logic               clk,
    input  logic               reset,
    input  logic               dataReq,
    input  memPkg::dataCommand dataCmd,
    input  memPkg::memResponse dataResp,
    output memPkg::memRequest  dataMemReq,
    output logic               dataDone,
    output logic               exception,
    output logic [31:0]        dataRdata
);

    logic              misaligned;
    logic [3:0]        storeEnable;
    logic [31:0]       laneData;
    logic              doneQ;
    logic              exceptionQ;
    memPkg::accessSize sizeQ;
    logic              signedQ;
    logic [1:0]        laneQ;
    logic [7:0]        byteSel;
    logic [15:0]       halfSel;

    always_comb begin
        misaligned = 1'b0;
        storeEnable = 4'b1111;
        laneData = dataCmd.wdata;
        case (dataCmd.size)
            memPkg::sizeByte: begin
                storeEnable = 4'b0001 << dataCmd.addr[1:0];
                laneData = {4{dataCmd.wdata[7:0]}};
            end
            memPkg::sizeHalf: begin
                misaligned = dataCmd.addr[0];
                storeEnable = dataCmd.addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{dataCmd.wdata[15:0]}};
            end
            default: begin
                misaligned = (dataCmd.addr[1:0] != 2'b00);
            end
        endcase
    end

    // a misaligned access never reaches the memory.
    always_comb begin
        dataMemReq.valid = dataReq && !misaligned;
        dataMemReq.write = dataCmd.write;
        dataMemReq.addr = {dataCmd.addr[31:2], 2'b00};
        dataMemReq.wdata = laneData;
        dataMemReq.byteEnable = storeEnable;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            doneQ <= 1'b0;
            exceptionQ <= 1'b0;
        end else begin
            doneQ <= dataReq;
            exceptionQ <= dataReq && misaligned;
        end
        if (dataReq) begin
            sizeQ <= dataCmd.size;                  // kept for the extension of the reply.
            signedQ <= dataCmd.signedLoad;
            laneQ <= dataCmd.addr[1:0];
        end
    end

    assign dataDone = doneQ;
    assign exception = exceptionQ;

    always_comb begin
        case (laneQ)
            2'd0: byteSel = dataResp.rdata[7:0];
            2'd1: byteSel = dataResp.rdata[15:8];
            2'd2: byteSel = dataResp.rdata[23:16];
            default: byteSel = dataResp.rdata[31:24];
        endcase
        halfSel = laneQ[1] ? dataResp.rdata[31:16] : dataResp.rdata[15:0];
        case (sizeQ)
            memPkg::sizeByte: dataRdata = {{24{signedQ && byteSel[7]}}, byteSel};
            memPkg::sizeHalf: dataRdata = {{16{signedQ && halfSel[15]}}, halfSel};
            default: dataRdata = dataResp.rdata;
        endcase
    end

    // an aligned access completes with its memory reply one cycle later.
    assert property (@(posedge clk) disable iff (reset)
        (dataReq && !misaligned) |=> (dataDone && dataResp.valid));

endmodule

// ==== logic/sramArbiter.sv ====
`timescale 1ns/100ps

module sramArbiter (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::memRequest  dataMemReq,
    input  memPkg::memRequest  fetchReq,
    output memPkg::memRequest  sramReq,
    input  memPkg::memResponse sramResp,
    output memPkg::memResponse dataResp,
    output memPkg::memResponse fetchResp
);

    logic dataGranted;   // the data peer owned the port in the previous cycle.

    // the data peer always wins. Fetch gets the port otherwise.
    assign sramReq = dataMemReq.valid ? dataMemReq : fetchReq;

    always_ff @(posedge clk) begin
        if (reset) begin
            dataGranted <= 1'b0;
        end else begin
            dataGranted <= dataMemReq.valid;
        end
    end

    // read data goes to both peers. Only the owner sees valid.
    always_comb begin
        dataResp.valid = sramResp.valid && dataGranted;
        dataResp.rdata = sramResp.rdata;
        fetchResp.valid = sramResp.valid && !dataGranted;
        fetchResp.rdata = sramResp.rdata;
    end

    // a data request is answered to the data peer alone on the next cycle.
    assert property (@(posedge clk) disable iff (reset)
        dataMemReq.valid |=> (dataResp.valid && !fetchResp.valid));

    // an uncontested fetch is answered to fetch alone on the next cycle.
    assert property (@(posedge clk) disable iff (reset)
        (fetchReq.valid && !dataMemReq.valid) |=> (fetchResp.valid && !dataResp.valid));

endmodule

// ==== logic/unifiedSram.sv ====
`timescale 1ns/100ps

module unifiedSram (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::memRequest  sramReq,
    output memPkg::memResponse sramResp
);

    logic [31:0]                    mem [memPkg::memWords];
    logic [memPkg::memIndexBits-1:0] index;
    logic                           respValid;
    logic [31:0]                    respData;

    // higher address bits are ignored, so all regions alias.
    assign index = sramReq.addr[memPkg::memIndexBits+1:2];

    always_ff @(posedge clk) begin
        if (sramReq.valid && sramReq.write) begin
            for (int i = 0; i < 4; i++) begin
                if (sramReq.byteEnable[i]) begin
                    mem[index][8*i +: 8] <= sramReq.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= sramReq.valid;             // writes are acknowledged too.
        end
        if (sramReq.valid && !sramReq.write) begin
            respData <= mem[index];
        end
    end

    assign sramResp.valid = respValid;
    assign sramResp.rdata = respData;

endmodule

// ==== logic/memorySubsystem.sv ====
`timescale 1ns/100ps

module memorySubsystem (
    input  logic               clk,
    input  logic               reset,
    input  logic               absJump,
    input  logic [31:0]        absJumpAddress,
    input  logic               pcStall,
    input  logic               hang,
    output logic [31:0]        outputPC,
    output logic [31:0]        instruction,
    output logic               fetchException,
    output logic               bubble,
    input  logic               dataReq,
    input  memPkg::dataCommand dataCmd,
    output logic               dataDone,
    output logic [31:0]        dataRdata,
    output logic               dataException
);

    memPkg::memRequest  fetchReq;
    memPkg::memRequest  dataMemReq;
    memPkg::memRequest  sramReq;
    memPkg::memResponse fetchResp;
    memPkg::memResponse dataResp;
    memPkg::memResponse sramResp;

    instructionFetch fetchUnit (
        .clk            (clk),
        .reset          (reset),
        .absJump        (absJump),
        .pcStall        (pcStall),
        .hang           (hang),
        .absJumpAddress (absJumpAddress),
        .fetchResp      (fetchResp),
        .fetchReq       (fetchReq),
        .outputPC       (outputPC),
        .instruction    (instruction),
        .exception      (fetchException),
        .bubble         (bubble)
    );

    dataAccess dataUnit (
        .clk        (clk),
        .reset      (reset),
        .dataReq    (dataReq),
        .dataCmd    (dataCmd),
        .dataResp   (dataResp),
        .dataMemReq (dataMemReq),
        .dataDone   (dataDone),
        .exception  (dataException),
        .dataRdata  (dataRdata)
    );

    sramArbiter arbiter (
        .clk        (clk),
        .reset      (reset),
        .dataMemReq (dataMemReq),
        .fetchReq   (fetchReq),
        .sramReq    (sramReq),
        .sramResp   (sramResp),
        .dataResp   (dataResp),
        .fetchResp  (fetchResp)
    );

    unifiedSram sram (
        .clk      (clk),
        .reset    (reset),
        .sramReq  (sramReq),
        .sramResp (sramResp)
    );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;               // four rising edges see reset high.
    end

endmodule

// ==== test/memorySubsystemTb.sv ====
`timescale 1ns/100ps

module memorySubsystemTb;

    localparam int resetCycles = 5;
    localparam int sequentialCycles = 70;
    localparam int loadStoreCycles = 40;
    localparam int contentionCycles = 75;
    localparam int pendingCycles = 30;
    localparam int hangCycles = 30;
    localparam int exceptionCycles = 30;
    localparam int watchdogCycles = 2 * (resetCycles + sequentialCycles + loadStoreCycles
        + contentionCycles + pendingCycles + hangCycles + exceptionCycles);
    localparam logic [31:0] bootPC = memPkg::resetVector;

    logic               clk;
    logic               reset;
    logic               absJump;
    logic [31:0]        absJumpAddress;
    logic               pcStall;
    logic               hang;
    logic [31:0]        outputPC;
    logic [31:0]        instruction;
    logic               fetchException;
    logic               bubble;
    logic               dataReq;
    memPkg::dataCommand dataCmd;
    logic               dataDone;
    logic [31:0]        dataRdata;
    logic               dataException;

    logic [31:0] model [memPkg::memWords];   // mirror of the SRAM, indexed by address bits 11:2.
    int          valueErrors;
    int          flowErrors;
    int          seedValue;
    logic        expDone;                    // expectations for the access of the last cycle.
    logic        expExc;
    logic        expLoad;
    logic [31:0] expRdata;
    logic        trackFetch;
    logic [31:0] expPC;
    int          fetchCount;

    clockGen clocks (.clk(clk), .reset(reset));

    memorySubsystem dut (.*);

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED %s: actual %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic reportFlow(input string what);
        flowErrors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    // drives one access and updates the model. The reply is checked on the next tick.
    task automatic issueAccess(input logic write, input memPkg::accessSize size,
                               input logic signedLoad, input logic [31:0] addr,
                               input logic [31:0] wdata);
        logic [31:0] word;
        logic [7:0]  lowByte;
        logic [15:0] lowHalf;
        logic        bad;
        word = model[addr[11:2]];
        bad = (size == memPkg::sizeWord) ? (addr[1:0] != 2'b00)
                                         : ((size == memPkg::sizeHalf) && addr[0]);
        if (write && !bad) begin
            case (size)
                memPkg::sizeByte: word[8*addr[1:0] +: 8] = wdata[7:0];
                memPkg::sizeHalf: word[16*addr[1] +: 16] = wdata[15:0];
                default: word = wdata;
            endcase
            model[addr[11:2]] = word;
        end
        lowByte = word[8*addr[1:0] +: 8];
        lowHalf = word[16*addr[1] +: 16];
        case (size)
            memPkg::sizeByte: expRdata = {24'h0, lowByte};
            memPkg::sizeHalf: expRdata = {16'h0, lowHalf};
            default: expRdata = word;
        endcase
        if (signedLoad && size == memPkg::sizeByte && lowByte[7]) expRdata |= 32'hFFFF_FF00;
        if (signedLoad && size == memPkg::sizeHalf && lowHalf[15]) expRdata |= 32'hFFFF_0000;
        expDone = 1'b1;
        expExc = bad;
        expLoad = !write && !bad;
        dataReq = 1'b1;
        dataCmd.write = write;
        dataCmd.size = size;
        dataCmd.signedLoad = signedLoad;
        dataCmd.addr = addr;
        dataCmd.wdata = wdata;
    endtask

    // one cycle: checks the data reply and any delivered instruction, then clears the strobe.
    task automatic tick();
        @(negedge clk);
        checkValue("dataDone", dataDone, expDone);
        checkValue("dataException", dataException, expExc);
        if (expLoad) checkValue("dataRdata", dataRdata, expRdata);
        if (trackFetch && !bubble) begin
            checkValue("outputPC", outputPC, expPC);
            checkValue("instruction", instruction, model[expPC[11:2]]);
            expPC = expPC + 32'd4;
            fetchCount++;
        end
        dataReq = 1'b0;
        expDone = 1'b0;
        expExc = 1'b0;
        expLoad = 1'b0;
    endtask

    task automatic jumpTo(input logic [31:0] target);
        absJump = 1'b1;
        absJumpAddress = target;
        tick();
        absJump = 1'b0;
    endtask

    // a jump may be deferred behind a pending read, so older PCs can still appear.
    task automatic awaitPC(input logic [31:0] target);
        int n;
        n = 0;
        while ((bubble || outputPC !== target) && n < 12) begin
            tick();
            n++;
        end
        if (bubble || outputPC !== target) reportFlow("fetch never reached the jump target");
        else checkValue("instruction", instruction, model[target[11:2]]);
        expPC = target + 32'd4;
        fetchCount = 1;
    endtask

    task automatic firstFetch(input logic [31:0] target);
        int n;
        n = 0;
        while (bubble && n < 8) begin
            tick();
            n++;
        end
        checkValue("bubble", bubble, 1'b0);
        checkValue("outputPC", outputPC, target);
        checkValue("instruction", instruction, model[target[11:2]]);
    endtask

    task automatic sequentialFetchTest();
        int n;
        for (int i = 0; i < 16; i++) begin
            tick();
            issueAccess(1'b1, memPkg::sizeWord, 1'b0, bootPC + 4 * i, $urandom);
        end
        tick();
        jumpTo(bootPC);
        awaitPC(bootPC);
        n = 0;
        trackFetch = 1'b1;
        while (fetchCount < 16 && n < 40) begin
            tick();
            n++;
        end
        trackFetch = 1'b0;
        if (fetchCount < 16) reportFlow("sequential fetch stopped delivering instructions");
    endtask

    task automatic loadStoreTest();
        tick();
        issueAccess(1'b1, memPkg::sizeWord, 1'b0, 32'h1000_0050, $urandom);
        tick();
        issueAccess(1'b1, memPkg::sizeWord, 1'b0, 32'h1000_0054, 32'h8C7F_F001);
        tick();
        issueAccess(1'b1, memPkg::sizeByte, 1'b0, 32'h1000_0051, $urandom);
        tick();
        issueAccess(1'b1, memPkg::sizeHalf, 1'b0, 32'h1000_0052, $urandom);
        tick();
        issueAccess(1'b1, memPkg::sizeByte, 1'b0, 32'h1000_0056, $urandom);
        for (int i = 0; i < 16; i++) begin           // the low alias reads the same words.
            tick();
            issueAccess(1'b0, memPkg::sizeByte, i[0], 32'h50 + i / 2, 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            tick();
            issueAccess(1'b0, memPkg::sizeHalf, i[0], 32'h50 + 2 * (i / 2), 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            tick();
            issueAccess(1'b0, memPkg::sizeWord, i[0], 32'h50 + 4 * (i / 2), 32'h0);
        end
        tick();
    endtask

    task automatic contentionTest();
        int n;
        jumpTo(bootPC);
        awaitPC(bootPC);
        n = 0;
        trackFetch = 1'b1;
        while (fetchCount < 12 && n < 60) begin
            tick();
            n++;
            if (n % 4 == 1) issueAccess(1'b1, memPkg::sizeByte, 1'b0, (n * 3) % 64, $urandom);
            if (n % 4 == 2) issueAccess(1'b0, memPkg::sizeHalf, n[2], (n * 6) % 64, 32'h0);
        end
        trackFetch = 1'b0;
        tick();
        if (fetchCount < 12) reportFlow("fetch starved while data accesses ran");
    endtask

    task automatic pendingJumpTest();
        pcStall = 1'b1;
        tick();
        tick();
        jumpTo(bootPC + 32'h20);                     // stored while the PC is stalled.
        tick();
        pcStall = 1'b0;
        tick();
        firstFetch(bootPC + 32'h20);
    endtask

    task automatic hangTest();
        jumpTo(bootPC + 32'h2);                      // park on a misaligned PC.
        awaitPC(bootPC + 32'h2);
        hang = 1'b1;
        tick();
        hang = 1'b0;
        for (int i = 0; i < 5; i++) begin
            checkValue("outputPC", outputPC, 32'h0);
            checkValue("instruction", instruction, 32'h0);
            checkValue("bubble", bubble, 1'b1);
            checkValue("fetchException", fetchException, 1'b0);
            tick();
        end
        jumpTo(bootPC + 32'h10);
        firstFetch(bootPC + 32'h10);
    endtask

    task automatic exceptionTest();
        jumpTo(bootPC + 32'h2);
        awaitPC(bootPC + 32'h2);
        checkValue("fetchException", fetchException, 1'b1);
        jumpTo(bootPC);
        awaitPC(bootPC);
        checkValue("fetchException", fetchException, 1'b0);
        tick();
        issueAccess(1'b1, memPkg::sizeHalf, 1'b0, 32'h0000_0055, $urandom);
        tick();
        issueAccess(1'b0, memPkg::sizeWord, 1'b0, 32'h0000_0054, 32'h0);
        tick();
    endtask

    initial begin
        #(watchdogCycles * 4);
        $display("ERROR: watchdog expired after %0d cycles before the tests ended", watchdogCycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seedValue = $urandom(83);
        absJump = 1'b0;
        absJumpAddress = 32'h0;
        pcStall = 1'b0;
        hang = 1'b0;
        dataReq = 1'b0;
        dataCmd = '0;
        valueErrors = 0;
        flowErrors = 0;
        expDone = 1'b0;
        expExc = 1'b0;
        expLoad = 1'b0;
        expRdata = 32'h0;
        trackFetch = 1'b0;
        expPC = 32'h0;
        fetchCount = 0;
        @(negedge reset);                            // registered outputs are settled here.
        checkValue("bubble", bubble, 1'b1);
        checkValue("dataDone", dataDone, 1'b0);
        checkValue("dataException", dataException, 1'b0);
        checkValue("fetchException", fetchException, 1'b0);
        sequentialFetchTest();
        loadStoreTest();
        contentionTest();
        pendingJumpTest();
        hangTest();
        exceptionTest();
        $display("Summary: %0d value mismatches, %0d other errors", valueErrors, flowErrors);
        if (valueErrors + flowErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== memorySubsystem.f ====
logic/memPkg.sv
logic/instructionFetch.sv
logic/dataAccess.sv
logic/sramArbiter.sv
logic/unifiedSram.sv
logic/memorySubsystem.sv
test/clockGen.sv
test/memorySubsystemTb.sv

// ==== Bender.yml ====
package:
  name: memory_subsystem

sources:
  - logic/memPkg.sv
  - logic/instructionFetch.sv
  - logic/dataAccess.sv
  - logic/sramArbiter.sv
  - logic/unifiedSram.sv
  - logic/memorySubsystem.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/memorySubsystemTb.sv
